/* badge_pkg.sv */
package badge_pkg;

  //////////////////////////////
  // bus fabric widths
  //////////////////////////////

  localparam int BUS_ADR_W = 16;
  localparam int BUS_DAT_W = 8;
  localparam int BUS_CTI_W = 3;

  typedef logic [BUS_ADR_W-1:0] bus_adr_t;
  typedef logic [BUS_DAT_W-1:0] bus_dat_t;
  typedef logic [BUS_CTI_W-1:0] bus_cti_t;

  // one master's request, plain level signalling
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    logic     sel;
    bus_cti_t cti;
    bus_adr_t adr;
    bus_dat_t dat;
  } bus_req_t;

  // slave reply
  typedef struct packed {
    logic     ack;
    bus_dat_t dat;
  } bus_rsp_t;

  //////////////////////////////
  // serial flash port
  //////////////////////////////

  localparam int SPI_LANES = 4;

  typedef logic [SPI_LANES-1:0] spi_nib_t;

  // pin drive, d_dir high means lane is driven
  typedef struct packed {
    logic     sck;
    logic     cs;
    spi_nib_t d_out;
    spi_nib_t d_dir;
  } spi_out_t;

  // usb dfu class state codes
  typedef enum logic [7:0] {
    DFU_APP_IDLE            = 8'h00,
    DFU_APP_DETACH          = 8'h01,
    DFU_IDLE                = 8'h02,
    DFU_DNLOAD_SYNC         = 8'h03,
    DFU_DN_BUSY             = 8'h04,
    DFU_DNLOAD_IDLE         = 8'h05,
    DFU_MANIFEST_SYNC       = 8'h06,
    DFU_MANIFEST            = 8'h07,
    DFU_MANIFEST_WAIT_RESET = 8'h08,
    DFU_UPLOAD_IDLE         = 8'h09,
    DFU_ERROR               = 8'h0a
  } dfu_state_e;

  //////////////////////////////
  // volume meter
  //////////////////////////////

  localparam int SAMPLE_W = 12;
  localparam int LEVEL_W  = 4;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [SAMPLE_W-1:0]        magnitude_t;
  typedef logic [LEVEL_W-1:0]         level_t;

  // largest magnitude, -2048 clips here
  localparam int MAG_MAX   = 2047;
  // full bar
  localparam int LEVEL_MAX = 10;
  // 200 hz update at 12 mhz
  localparam int WINDOW_CYCLES_DEFAULT = 60000;

endpackage

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  badge_pkg::bus_req_t led_req_i,
  input  badge_pkg::bus_req_t pat_req_i,
  input  badge_pkg::bus_rsp_t mtx_rsp_i,
  input  badge_pkg::bus_rsp_t mem_rsp_i,
  output badge_pkg::bus_req_t slv_req_o,
  output badge_pkg::bus_rsp_t mst_rsp_o,
  output logic                led_taken_o,
  output logic                pat_taken_o
);

  //////////////////////////////
  // request side
  //////////////////////////////

  // fetcher wins whenever its cyc is up
  // writer only gets the bus while fetcher is idle
  // nobody active, slaves see an idle bus
  always_comb begin
    if (led_req_i.cyc) begin
      slv_req_o = led_req_i;
    end else if (pat_req_i.cyc) begin
      slv_req_o = pat_req_i;
    end else begin
      slv_req_o = '0;
    end
  end

  // each master backs off while the other holds cyc
  // fetcher sees writer's cyc
  assign led_taken_o = pat_req_i.cyc;
  // writer sees fetcher's cyc
  assign pat_taken_o = led_req_i.cyc;

  //////////////////////////////
  // reply side
  //////////////////////////////

  // either slave may finish the cycle
  assign mst_rsp_o.ack = mtx_rsp_i.ack | mem_rsp_i.ack;

  // matrix registers first, then frame memory
  // data stays zero with no ack so a master never latches junk
  always_comb begin
    if (mtx_rsp_i.ack) begin
      mst_rsp_o.dat = mtx_rsp_i.dat;
    end else if (mem_rsp_i.ack) begin
      mst_rsp_o.dat = mem_rsp_i.dat;
    end else begin
      mst_rsp_o.dat = '0;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // address decode in the two slaves must never overlap
  // checked once the time step has settled
  always_comb begin
    a_one_ack : assert final (!(mtx_rsp_i.ack && mem_rsp_i.ack))
      else $error("both slaves acked the same bus cycle");
  end

endmodule

/* flash_port_mux.sv */
`timescale 1ns/1ps

module flash_port_mux (
  input  logic                  clk,
  input  logic                  reset_i,
  input  badge_pkg::dfu_state_e dfu_state_i,
  input  logic                  mem_busy_i,
  input  badge_pkg::spi_out_t   mem_spi_i,
  output badge_pkg::spi_nib_t   mem_d_in_o,
  input  logic                  dfu_sck_i,
  input  logic                  dfu_cs_i,
  input  logic                  dfu_mosi_i,
  output logic                  dfu_miso_o,
  input  badge_pkg::spi_nib_t   pad_d_in_i,
  output badge_pkg::spi_out_t   pad_spi_o,
  output logic                  dfu_busy_o,
  output logic                  flash_busy_o,
  output logic                  usb_to_flash_o,
  output logic                  flash_to_usb_o
);

  //////////////////////////////
  // dfu state decode
  //////////////////////////////

  // only the three resting states leave the flash alone
  // unknown codes fall into default and count as busy
  always_comb begin
    dfu_busy_o     = 1'b1;
    usb_to_flash_o = 1'b0;
    flash_to_usb_o = 1'b0;
    case (dfu_state_i)
      badge_pkg::DFU_APP_IDLE,
      badge_pkg::DFU_APP_DETACH,
      badge_pkg::DFU_IDLE: begin
        dfu_busy_o = 1'b0;
      end
      // download path, host writes flash
      badge_pkg::DFU_DNLOAD_SYNC,
      badge_pkg::DFU_DN_BUSY,
      badge_pkg::DFU_DNLOAD_IDLE: begin
        usb_to_flash_o = 1'b1;
      end
      // upload path, host reads flash
      badge_pkg::DFU_UPLOAD_IDLE: begin
        flash_to_usb_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // frame memory stalls on either owner
  assign flash_busy_o = dfu_busy_o | mem_busy_i;

  //////////////////////////////
  // pin ownership
  //////////////////////////////

  // dfu core is plain single-lane spi
  // mosi on lane 0, miso comes back on lane 1
  // memory controller is starved of input while dfu owns the pins
  always_comb begin
    if (dfu_busy_o) begin
      pad_spi_o.sck   = dfu_sck_i;
      pad_spi_o.cs    = dfu_cs_i;
      pad_spi_o.d_out = {3'b000, dfu_mosi_i};
      pad_spi_o.d_dir = 4'b0001;
      dfu_miso_o      = pad_d_in_i[1];
      mem_d_in_o      = '0;
    end else begin
      // straight through for the quad capable controller
      pad_spi_o  = mem_spi_i;
      mem_d_in_o = pad_d_in_i;
      dfu_miso_o = 1'b0;
    end
  end

  // upper lanes stay released for the whole dfu session
  a_dfu_lanes : assert property (@(posedge clk) disable iff (reset_i)
    dfu_busy_o |-> (pad_spi_o.d_dir[3:1] == 3'b000))
    else $error("flash lanes 1-3 driven while dfu owns the port");

endmodule

/* volume_meter.sv */
`timescale 1ns/1ps

module volume_meter #(
  parameter int WINDOW_CYCLES = badge_pkg::WINDOW_CYCLES_DEFAULT
) (
  input  logic                clk,
  input  logic                reset_i,
  input  badge_pkg::sample_t  sample_i,
  input  logic                sample_valid_i,
  output badge_pkg::level_t   level_o,
  output logic                level_strobe_o
);

  // counter wide enough for window minus one
  localparam int CNT_W = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(WINDOW_CYCLES - 1);

  //////////////////////////////
  // bar level lookup
  //////////////////////////////

  // log-ish scale on the top set bit
  // bits 3..0 are noise floor and read as silence
  function automatic badge_pkg::level_t quantize(input badge_pkg::magnitude_t mag);
    badge_pkg::level_t lvl;
    if (mag[11] || mag[10]) begin
      lvl = 4'(badge_pkg::LEVEL_MAX);
    end else if (mag[9]) begin
      lvl = 4'd8;
    end else if (mag[8]) begin
      lvl = 4'd6;
    end else if (mag[7]) begin
      lvl = 4'd4;
    end else if (mag[6]) begin
      lvl = 4'd3;
    end else if (mag[5]) begin
      lvl = 4'd2;
    end else if (mag[4]) begin
      lvl = 4'd1;
    end else begin
      lvl = 4'd0;
    end
    return lvl;
  endfunction

  //////////////////////////////
  // rectifier
  //////////////////////////////

  logic [badge_pkg::SAMPLE_W-1:0] neg_sample;
  badge_pkg::magnitude_t          mag;

  // two's complement negate
  assign neg_sample = ~sample_i + 1'b1;

  // -2048 negates back onto itself, clip to 2047
  always_comb begin
    if (!sample_i[badge_pkg::SAMPLE_W-1]) begin
      mag = sample_i;
    end else if (neg_sample[badge_pkg::SAMPLE_W-1]) begin
      mag = badge_pkg::SAMPLE_W'(badge_pkg::MAG_MAX);
    end else begin
      mag = neg_sample;
    end
  end

  //////////////////////////////
  // window peak hold
  //////////////////////////////

  logic [CNT_W-1:0]      cnt_q;
  badge_pkg::magnitude_t peak_q;
  badge_pkg::magnitude_t peak_nxt;
  logic                  win_end;

  // last cycle of the window
  assign win_end = (cnt_q == '0);

  // include this cycle's sample so the final one is not lost
  assign peak_nxt = (sample_valid_i && (mag > peak_q)) ? mag : peak_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt_q          <= CNT_RELOAD;
      peak_q         <= '0;
      level_o        <= '0;
      level_strobe_o <= 1'b0;
    end else begin
      // one-cycle pulse following the window end
      level_strobe_o <= win_end;
      if (win_end) begin
        cnt_q   <= CNT_RELOAD;
        peak_q  <= '0;
        level_o <= quantize(peak_nxt);
      end else begin
        cnt_q  <= cnt_q - 1'b1;
        peak_q <= peak_nxt;
      end
    end
  end

  // pattern writer indexes its bar table with this
  a_level_range : assert property (@(posedge clk) disable iff (reset_i)
    level_o <= badge_pkg::LEVEL_MAX)
    else $error("level above full bar");

  // redraw request is a single pulse per window
  a_strobe_pulse : assert property (@(posedge clk) disable iff (reset_i)
    level_strobe_o |=> !level_strobe_o)
    else $error("level strobe held two cycles");

endmodule

/* led_badge_top.sv */
`timescale 1ns/1ps

module led_badge_top #(
  parameter int WINDOW_CYCLES = badge_pkg::WINDOW_CYCLES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset_i,
  // bus masters and slaves
  input  badge_pkg::bus_req_t   led_req_i,
  input  badge_pkg::bus_req_t   pat_req_i,
  input  badge_pkg::bus_rsp_t   mtx_rsp_i,
  input  badge_pkg::bus_rsp_t   mem_rsp_i,
  output badge_pkg::bus_req_t   slv_req_o,
  output badge_pkg::bus_rsp_t   mst_rsp_o,
  output logic                  led_taken_o,
  output logic                  pat_taken_o,
  // dfu and serial flash
  input  badge_pkg::dfu_state_e dfu_state_i,
  input  logic                  mem_busy_i,
  input  badge_pkg::spi_out_t   mem_spi_i,
  output badge_pkg::spi_nib_t   mem_d_in_o,
  input  logic                  dfu_sck_i,
  input  logic                  dfu_cs_i,
  input  logic                  dfu_mosi_i,
  output logic                  dfu_miso_o,
  input  badge_pkg::spi_nib_t   pad_d_in_i,
  output badge_pkg::spi_out_t   pad_spi_o,
  output logic                  dfu_busy_o,
  output logic                  flash_busy_o,
  output logic                  usb_to_flash_o,
  output logic                  flash_to_usb_o,
  // microphone samples in, vu level out
  input  badge_pkg::sample_t    sample_i,
  input  logic                  sample_valid_i,
  output badge_pkg::level_t     level_o,
  output logic                  level_strobe_o
);

  //////////////////////////////
  // shared bus
  //////////////////////////////

  // frame fetcher and pattern writer onto matrix regs and frame memory
  bus_arbiter u_bus_arbiter (
    .led_req_i   (led_req_i),
    .pat_req_i   (pat_req_i),
    .mtx_rsp_i   (mtx_rsp_i),
    .mem_rsp_i   (mem_rsp_i),
    .slv_req_o   (slv_req_o),
    .mst_rsp_o   (mst_rsp_o),
    .led_taken_o (led_taken_o),
    .pat_taken_o (pat_taken_o)
  );

  //////////////////////////////
  // flash pins
  //////////////////////////////

  flash_port_mux u_flash_port_mux (
    .clk            (clk),
    .reset_i        (reset_i),
    .dfu_state_i    (dfu_state_i),
    .mem_busy_i     (mem_busy_i),
    .mem_spi_i      (mem_spi_i),
    .mem_d_in_o     (mem_d_in_o),
    .dfu_sck_i      (dfu_sck_i),
    .dfu_cs_i       (dfu_cs_i),
    .dfu_mosi_i     (dfu_mosi_i),
    .dfu_miso_o     (dfu_miso_o),
    .pad_d_in_i     (pad_d_in_i),
    .pad_spi_o      (pad_spi_o),
    .dfu_busy_o     (dfu_busy_o),
    .flash_busy_o   (flash_busy_o),
    .usb_to_flash_o (usb_to_flash_o),
    .flash_to_usb_o (flash_to_usb_o)
  );

  //////////////////////////////
  // vu meter
  //////////////////////////////

  // level feeds the pattern writer outside
  volume_meter #(
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) u_volume_meter (
    .clk            (clk),
    .reset_i        (reset_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .level_o        (level_o),
    .level_strobe_o (level_strobe_o)
  );

endmodule

/* tb_led_badge.sv */
`timescale 1ns/1ps

module tb_led_badge;

  // short window so many windows fit in one run
  localparam int WINDOW = 64;
  localparam int WINDOWS_TO_CHECK = 24;

  logic                  clk;
  logic                  reset_i;
  logic                  reset_next;
  badge_pkg::bus_req_t   led_req, pat_req, slv_req;
  badge_pkg::bus_rsp_t   mtx_rsp, mem_rsp, mst_rsp;
  logic                  led_taken, pat_taken;
  badge_pkg::dfu_state_e dfu_state;
  logic                  mem_busy;
  badge_pkg::spi_out_t   mem_spi, pad_spi;
  badge_pkg::spi_nib_t   mem_d_in, pad_d_in;
  logic                  dfu_sck, dfu_cs, dfu_mosi, dfu_miso;
  logic                  dfu_busy, flash_busy, usb_to_flash, flash_to_usb;
  badge_pkg::sample_t    sample;
  logic                  sample_valid;
  badge_pkg::level_t     level;
  logic                  level_strobe;

  int    errors;
  int    checks;
  string phase;

  // largest sample magnitude the stimulus produces
  int amp;

  // meter model state
  int   m_cnt;
  int   m_peak;
  int   m_level;
  logic m_strobe;

  led_badge_top #(.WINDOW_CYCLES(WINDOW)) u_dut (
    .clk (clk), .reset_i (reset_i),
    .led_req_i (led_req), .pat_req_i (pat_req),
    .mtx_rsp_i (mtx_rsp), .mem_rsp_i (mem_rsp),
    .slv_req_o (slv_req), .mst_rsp_o (mst_rsp),
    .led_taken_o (led_taken), .pat_taken_o (pat_taken),
    .dfu_state_i (dfu_state), .mem_busy_i (mem_busy),
    .mem_spi_i (mem_spi), .mem_d_in_o (mem_d_in),
    .dfu_sck_i (dfu_sck), .dfu_cs_i (dfu_cs), .dfu_mosi_i (dfu_mosi),
    .dfu_miso_o (dfu_miso), .pad_d_in_i (pad_d_in), .pad_spi_o (pad_spi),
    .dfu_busy_o (dfu_busy), .flash_busy_o (flash_busy),
    .usb_to_flash_o (usb_to_flash), .flash_to_usb_o (flash_to_usb),
    .sample_i (sample), .sample_valid_i (sample_valid),
    .level_o (level), .level_strobe_o (level_strobe)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // absolute value, clipped at 2047
  function automatic int mag_of(input badge_pkg::sample_t s);
    int v;
    v = int'(s);
    if (v < 0) v = -v;
    if (v > 2047) v = 2047;
    return v;
  endfunction

  // bar level from the top set bit
  function automatic int level_of(input int mag);
    logic [11:0] m;
    int          top;
    m   = 12'(mag);
    top = -1;
    for (int b = 0; b < 12; b++) begin
      if (m[b]) top = b;
    end
    case (top)
      11, 10:  return 10;
      9:       return 8;
      8:       return 6;
      7:       return 4;
      6:       return 3;
      5:       return 2;
      4:       return 1;
      default: return 0;
    endcase
  endfunction

  // one clock edge of the meter, on the inputs the dut samples
  task automatic model_edge();
    int cur;
    int top;
    if (reset_i) begin
      m_cnt    = WINDOW - 1;
      m_peak   = 0;
      m_level  = 0;
      m_strobe = 1'b0;
    end else begin
      cur      = sample_valid ? mag_of(sample) : 0;
      top      = (cur > m_peak) ? cur : m_peak;
      m_strobe = (m_cnt == 0);
      if (m_cnt == 0) begin
        m_level = level_of(top);
        m_peak  = 0;
        m_cnt   = WINDOW - 1;
      end else begin
        m_cnt  = m_cnt - 1;
        m_peak = top;
      end
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // legal codes plus a few illegal ones
  function automatic logic [7:0] rand_code();
    return 8'($urandom_range(0, 15));
  endfunction

  task automatic drive_inputs(input logic [7:0] code);
    int sel;
    int lim;
    // bus, at most one slave acks
    led_req <= badge_pkg::bus_req_t'(30'($urandom));
    pat_req <= badge_pkg::bus_req_t'(30'($urandom));
    sel = int'($urandom % 3);
    mtx_rsp <= badge_pkg::bus_rsp_t'({sel == 1, 8'($urandom)});
    mem_rsp <= badge_pkg::bus_rsp_t'({sel == 2, 8'($urandom)});
    // flash side
    dfu_state <= badge_pkg::dfu_state_e'(code);
    mem_busy  <= 1'($urandom);
    mem_spi   <= badge_pkg::spi_out_t'(10'($urandom));
    dfu_sck   <= 1'($urandom);
    dfu_cs    <= 1'($urandom);
    dfu_mosi  <= 1'($urandom);
    pad_d_in  <= 4'($urandom);
    // samples, extremes and small values mixed in, all within amp
    lim = (amp < 40) ? amp : 40;
    sel = int'($urandom % 8);
    case (sel)
      0:       sample <= (amp >= 2047) ? 12'sh800 : 12'(-amp);
      1:       sample <= 12'(amp);
      2, 3:    sample <= 12'(int'($urandom_range(0, 2 * lim)) - lim);
      default: sample <= 12'(int'($urandom_range(0, 2 * amp)) - amp);
    endcase
    sample_valid <= (($urandom % 4) != 0);
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("** Error %s/%s: expected %0h, actual %0h", phase, name, exp_v, act_v);
    end
  endtask

  task automatic check_outputs();
    badge_pkg::bus_req_t exp_req;
    badge_pkg::bus_rsp_t exp_rsp;
    badge_pkg::spi_out_t exp_pad;
    badge_pkg::spi_nib_t exp_din;
    logic                exp_miso;
    logic                exp_busy;
    int                  c;
    // fixed priority, fetcher first
    exp_req = '0;
    if (led_req.cyc) exp_req = led_req;
    else if (pat_req.cyc) exp_req = pat_req;
    check_eq("slv_req", 32'(exp_req), 32'(slv_req));
    check_eq("led_taken", 32'(pat_req.cyc), 32'(led_taken));
    check_eq("pat_taken", 32'(led_req.cyc), 32'(pat_taken));
    // reply merge
    exp_rsp.ack = mtx_rsp.ack | mem_rsp.ack;
    exp_rsp.dat = '0;
    if (mtx_rsp.ack) exp_rsp.dat = mtx_rsp.dat;
    else if (mem_rsp.ack) exp_rsp.dat = mem_rsp.dat;
    check_eq("mst_rsp", 32'(exp_rsp), 32'(mst_rsp));
    // dfu flags from the raw code
    c        = int'(dfu_state);
    exp_busy = !(c == 0 || c == 1 || c == 2);
    check_eq("dfu_busy", 32'(exp_busy), 32'(dfu_busy));
    check_eq("flash_busy", 32'(exp_busy | mem_busy), 32'(flash_busy));
    check_eq("usb_to_flash", 32'(c >= 3 && c <= 5), 32'(usb_to_flash));
    check_eq("flash_to_usb", 32'(c == 9), 32'(flash_to_usb));
    // pin owner
    if (exp_busy) begin
      exp_pad.sck   = dfu_sck;
      exp_pad.cs    = dfu_cs;
      exp_pad.d_out = {3'b000, dfu_mosi};
      exp_pad.d_dir = 4'b0001;
      exp_din       = '0;
      exp_miso      = pad_d_in[1];
    end else begin
      exp_pad  = mem_spi;
      exp_din  = pad_d_in;
      exp_miso = 1'b0;
    end
    check_eq("pad_spi", 32'(exp_pad), 32'(pad_spi));
    check_eq("mem_d_in", 32'(exp_din), 32'(mem_d_in));
    check_eq("dfu_miso", 32'(exp_miso), 32'(dfu_miso));
    // meter registers
    check_eq("level", 32'(m_level), 32'(level));
    check_eq("level_strobe", 32'(m_strobe), 32'(level_strobe));
  endtask

  // one clock: model, new inputs, then look once things settle
  task automatic step(input logic [7:0] code);
    @(posedge clk);
    model_edge();
    reset_i <= reset_next;
    drive_inputs(code);
    #1;
    check_outputs();
  endtask

  task automatic wait_strobe(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < limit && !seen; n++) begin
      step(rand_code());
      if (level_strobe) seen = 1'b1;
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    int i;
    bit seen;
    errors = 0;
    checks = 0;
    phase  = "reset";
    void'($urandom(32'hdc82_a1c5));
    amp = 2047;
    m_cnt = 0;
    m_peak = 0;
    m_level = 0;
    m_strobe = 1'b0;
    reset_next = 1'b1;
    reset_i <= 1'b1;
    led_req <= '0;
    pat_req <= '0;
    mtx_rsp <= '0;
    mem_rsp <= '0;
    dfu_state <= badge_pkg::DFU_APP_IDLE;
    mem_busy <= 1'b0;
    mem_spi <= '0;
    dfu_sck <= 1'b0;
    dfu_cs <= 1'b0;
    dfu_mosi <= 1'b0;
    pad_d_in <= '0;
    sample <= '0;
    sample_valid <= 1'b0;
    // three edges in reset
    step(8'h00);
    step(8'h00);
    reset_next = 1'b0;
    step(8'h00);
    // quiet for the whole first window
    for (i = 0; i < WINDOW - 1; i++) begin
      step(rand_code());
      check_eq("level_after_reset", 32'd0, 32'(level));
      check_eq("strobe_after_reset", 32'd0, 32'(level_strobe));
    end
    phase = "arbitration";
    repeat (300) step(rand_code());
    // every code, illegal ones too
    phase = "dfu_decode";
    for (i = 0; i < 256; i++) step(8'(i));
    phase = "flash_pins";
    repeat (200) step(rand_code());
    phase = "volume";
    for (i = 0; i < WINDOWS_TO_CHECK; i++) begin
      // new loudness per window so every bar height shows up
      amp = (1 << $urandom_range(0, 11)) - 1;
      wait_strobe(2 * WINDOW, seen);
      if (!seen) begin
        errors++;
        $display("timeout: no level strobe within %0d cycles", 2 * WINDOW);
        break;
      end
      check_eq("window_level", 32'(m_level), 32'(level));
      // pulse is one cycle wide
      step(rand_code());
      check_eq("strobe_width", 32'd0, 32'(level_strobe));
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* led_badge.f */
badge_pkg.sv
bus_arbiter.sv
flash_port_mux.sv
volume_meter.sv
led_badge_top.sv
tb_led_badge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the led badge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_led_badge \
  -f led_badge.f \
  -o tb_led_badge > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_led_badge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi

exit 0
